//--- mempool_system.f
hdl/mempool_system_pkg.sv
hdl/mem_bus_if.sv
hdl/addr_decoder.sv
hdl/l2_mem.sv
hdl/bootrom.sv
hdl/ctrl_registers.sv
hdl/mempool_system.sv
dv/tb_mempool_system.sv

//--- dv/tb_mempool_system.sv
// Directed testbench for the MemPool system
// Host port traffic to L2, boot ROM, control registers and unmapped space

module tb_mempool_system;

  localparam int unsigned MaxCycles = 2000; // Well above the length of the directed tests
  localparam int unsigned L2Words = mempool_system_pkg::NumL2Banks *
                                    mempool_system_pkg::L2BankNumWords;

  logic                           clk;
  logic                           reset;
  logic                           req;
  logic                           we;
  mempool_system_pkg::addr_t      addr;
  mempool_system_pkg::data_t      wdata;
  mempool_system_pkg::strb_t      be;
  logic                           rvalid;
  mempool_system_pkg::data_t      rdata;
  logic                           err;
  logic                           eoc_valid;
  mempool_system_pkg::core_mask_t wake_up;

  // Expected response of the request issued in the previous cycle
  logic                           pend_valid;
  mempool_system_pkg::addr_t      pend_addr;
  mempool_system_pkg::data_t      pend_rdata;
  logic                           pend_err;
  mempool_system_pkg::core_mask_t pend_wake;
  logic                           pend_eoc;

  logic                           eoc_model;
  mempool_system_pkg::data_t      l2_model [L2Words];
  int unsigned                    errors;
  int unsigned                    cycle_count;

  mempool_system i_mempool_system (
    .clk_i      (clk      ),
    .reset_i    (reset    ),
    .req_i      (req      ),
    .we_i       (we       ),
    .addr_i     (addr     ),
    .wdata_i    (wdata    ),
    .be_i       (be       ),
    .rvalid_o   (rvalid   ),
    .rdata_o    (rdata    ),
    .err_o      (err      ),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up  )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("Simulation stopped after %0d cycles without finishing the tests", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_data(input string name, input mempool_system_pkg::data_t got,
                            input mempool_system_pkg::data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h at time %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input mempool_system_pkg::core_mask_t got,
                            input mempool_system_pkg::core_mask_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h at time %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h at time %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // One clock cycle: check last cycle's response, then drive the next request
  task automatic bus_cycle(input logic req_v, input logic we_v,
                           input mempool_system_pkg::addr_t addr_v,
                           input mempool_system_pkg::data_t wdata_v,
                           input mempool_system_pkg::strb_t be_v,
                           input mempool_system_pkg::data_t exp_rdata,
                           input logic exp_err,
                           input mempool_system_pkg::core_mask_t exp_wake);
    @(posedge clk);
    #5;
    if (rvalid !== pend_valid) begin
      errors++;
      if (pend_valid) $display("No response one cycle after request to %h", pend_addr);
      else $display("Response at time %0t without a request in the cycle before", $time);
    end else if (pend_valid) begin
      check_data("rdata_o", rdata, pend_rdata);
    end
    check_bit("err_o", err, pend_err);
    check_mask("wake_up_o", wake_up, pend_wake);
    check_bit("eoc_valid_o", eoc_valid, pend_eoc);
    if (req_v && we_v && !exp_err &&
        addr_v == mempool_system_pkg::CtrlBaseAddr + mempool_system_pkg::EocOffset) begin
      eoc_model = wdata_v[0];
    end
    req        = req_v;
    we         = we_v;
    addr       = addr_v;
    wdata      = wdata_v;
    be         = be_v;
    pend_valid = req_v;
    pend_addr  = addr_v;
    pend_rdata = exp_rdata;
    pend_err   = req_v && exp_err;
    pend_wake  = exp_wake;
    pend_eoc   = eoc_model;
  endtask

  task automatic write_word(input mempool_system_pkg::addr_t a, input mempool_system_pkg::data_t d,
                            input mempool_system_pkg::strb_t b, input logic exp_err,
                            input mempool_system_pkg::core_mask_t exp_wake);
    bus_cycle(1'b1, 1'b1, a, d, b, '0, exp_err, exp_wake); // Writes answer with zero data
  endtask

  task automatic read_word(input mempool_system_pkg::addr_t a,
                           input mempool_system_pkg::data_t exp_rdata, input logic exp_err);
    bus_cycle(1'b1, 1'b0, a, '0, '1, exp_rdata, exp_err, '0);
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, 1'b0, '0, '0, '0, '0, 1'b0, '0);
  endtask

  task automatic test_reset();
    check_bit("rvalid_o", rvalid, 1'b0);
    check_bit("err_o", err, 1'b0);
    check_bit("eoc_valid_o", eoc_valid, 1'b0);
    check_mask("wake_up_o", wake_up, '0);
  endtask

  task automatic test_l2();
    int unsigned               idx;
    mempool_system_pkg::data_t d;
    mempool_system_pkg::strb_t b;
    // Stride of 17 words walks all banks and many rows
    for (int i = 0; i < 16; i++) begin
      idx = i * 17;
      d = $urandom();
      l2_model[idx] = d;
      write_word(mempool_system_pkg::L2BaseAddr + idx * 4, d, 4'hF, 1'b0, '0);
    end
    for (int i = 0; i < 16; i++) begin
      idx = i * 17;
      read_word(mempool_system_pkg::L2BaseAddr + idx * 4, l2_model[idx], 1'b0);
    end
    idx = 5 * 17;   // Partial write, bytes 0 and 2
    d = $urandom();
    b = 4'b0101;
    for (int i = 0; i < 4; i++) begin
      if (b[i]) l2_model[idx][i*8 +: 8] = d[i*8 +: 8];
    end
    write_word(mempool_system_pkg::L2BaseAddr + idx * 4, d, b, 1'b0, '0);
    read_word(mempool_system_pkg::L2BaseAddr + idx * 4, l2_model[idx], 1'b0);
    idle_cycle();
  endtask

  task automatic test_bootrom();
    for (int i = 0; i < mempool_system_pkg::BootromNumWords; i++) begin
      read_word(mempool_system_pkg::BootromBaseAddr + i * 4,
                mempool_system_pkg::BootromWords[i], 1'b0);
    end
    read_word(mempool_system_pkg::BootromBaseAddr + 32'h20, '0, 1'b0); // Past the table
    write_word(mempool_system_pkg::BootromBaseAddr + 32'h4, 32'hDEAD_BEEF, 4'hF, 1'b1, '0);
    read_word(mempool_system_pkg::BootromBaseAddr + 32'h4,
              mempool_system_pkg::BootromWords[1], 1'b0);
    idle_cycle();
  endtask

  task automatic test_ctrl();
    mempool_system_pkg::addr_t base;
    base = mempool_system_pkg::CtrlBaseAddr;
    read_word(base + mempool_system_pkg::NumCoresOffset, 32'd8, 1'b0);
    write_word(base + mempool_system_pkg::EocOffset, 32'd1, 4'hF, 1'b0, '0);
    read_word(base + mempool_system_pkg::EocOffset, 32'd1, 1'b0);
    write_word(base + mempool_system_pkg::EocOffset, 32'd0, 4'hF, 1'b0, '0);
    write_word(base + mempool_system_pkg::NumCoresOffset, 32'd4, 4'hF, 1'b1, '0);
    read_word(base + 32'h10, '0, 1'b1);  // Unknown offset
    write_word(base + 32'h0C, 32'h1234_5678, 4'hF, 1'b1, '0);
    idle_cycle();
  endtask

  task automatic test_wake_up();
    mempool_system_pkg::addr_t a;
    a = mempool_system_pkg::CtrlBaseAddr + mempool_system_pkg::WakeUpOffset;
    write_word(a, 32'd3, 4'hF, 1'b0, 8'h08);
    idle_cycle();   // Pulse must be gone again
    write_word(a, mempool_system_pkg::WakeAll, 4'hF, 1'b0, 8'hFF);
    write_word(a, 32'd9, 4'hF, 1'b0, '0);
    read_word(a, '0, 1'b0);
    idle_cycle();
  endtask

  task automatic test_unmapped();
    read_word(32'h2000_0000, '0, 1'b1);
    write_word(mempool_system_pkg::L2BaseAddr + L2Words * 4, 32'hCAFE_F00D, 4'hF, 1'b1, '0);
    idle_cycle();
  endtask

  initial begin
    void'($urandom(53233));
    errors      = 0;
    cycle_count = 0;
    eoc_model   = 1'b0;
    pend_valid  = 1'b0;
    pend_addr   = '0;
    pend_rdata  = '0;
    pend_err    = 1'b0;
    pend_wake   = '0;
    pend_eoc    = 1'b0;
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    be    = '0;
    repeat (3) @(posedge clk);
    #5;
    reset = 1'b0;

    test_reset();
    test_l2();
    test_bootrom();
    test_ctrl();
    test_wake_up();
    test_unmapped();

    $display("Tests finished after %0d cycles with %0d errors", cycle_count, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_mempool_system

//--- hdl/mempool_system.sv
// MemPool system top level
// Host port decoded to L2, boot ROM and control registers

module mempool_system (
  input  logic                           clk_i,
  input  logic                           reset_i,

  // Host request port
  input  logic                           req_i,
  input  logic                           we_i,
  input  mempool_system_pkg::addr_t      addr_i,
  input  mempool_system_pkg::data_t      wdata_i,
  input  mempool_system_pkg::strb_t      be_i,
  output logic                           rvalid_o,
  output mempool_system_pkg::data_t      rdata_o,
  output logic                           err_o,

  // Towards the cluster
  output logic                           eoc_valid_o,
  output mempool_system_pkg::core_mask_t wake_up_o
);

  mem_bus_if l2_bus   ();
  mem_bus_if rom_bus  ();
  mem_bus_if ctrl_bus ();

  addr_decoder i_addr_decoder (
    .clk_i   (clk_i   ),
    .reset_i (reset_i ),
    .req_i   (req_i   ),
    .we_i    (we_i    ),
    .addr_i  (addr_i  ),
    .wdata_i (wdata_i ),
    .be_i    (be_i    ),
    .rvalid_o(rvalid_o),
    .rdata_o (rdata_o ),
    .err_o   (err_o   ),
    .l2      (l2_bus  ),
    .rom     (rom_bus ),
    .ctrl    (ctrl_bus)
  );

  l2_mem i_l2_mem (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .bus    (l2_bus )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .bus    (rom_bus)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .bus        (ctrl_bus   ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule : mempool_system

//--- hdl/ctrl_registers.sv
// Control registers
// End-of-computation flag, per-core wake-up pulses and the core count

module ctrl_registers (
  input  logic                           clk_i,
  input  logic                           reset_i,
  mem_bus_if.target                      bus,
  output logic                           eoc_valid_o,
  output mempool_system_pkg::core_mask_t wake_up_o
);

  mempool_system_pkg::addr_t      offset;
  mempool_system_pkg::data_t      eoc_q;
  mempool_system_pkg::data_t      rdata_d, rdata_q;
  mempool_system_pkg::core_mask_t wake_up_d, wake_up_q;
  logic                           err_d, err_q;
  logic                           rvalid_q;

  assign offset = bus.addr - mempool_system_pkg::CtrlBaseAddr;

  // Register access, byte enables are ignored here
  always_comb begin
    rdata_d   = '0;
    err_d     = 1'b0;
    wake_up_d = '0;
    if (bus.req) begin
      unique case (offset)
        mempool_system_pkg::EocOffset: begin
          if (!bus.we) rdata_d = eoc_q;
        end
        mempool_system_pkg::WakeUpOffset: begin
          if (bus.we) begin   // Reads return zero
            if (bus.wdata == mempool_system_pkg::WakeAll) begin
              wake_up_d = '1;
            end else if (bus.wdata < mempool_system_pkg::NumCores) begin
              wake_up_d = mempool_system_pkg::core_mask_t'(1) << bus.wdata;
            end
          end
        end
        mempool_system_pkg::NumCoresOffset: begin
          if (bus.we) err_d = 1'b1; // Read-only
          else rdata_d = mempool_system_pkg::NumCores;
        end
        default: err_d = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
      rvalid_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      rvalid_q  <= bus.req;
      err_q     <= err_d;
      wake_up_q <= wake_up_d;   // One-cycle pulse, lines up with the response
      if (bus.req && bus.we && offset == mempool_system_pkg::EocOffset) begin
        eoc_q <= bus.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.err     = err_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

endmodule : ctrl_registers

//--- hdl/bootrom.sv
// Boot ROM
// Serves the boot program, writes are rejected with an error

module bootrom (
  input  logic      clk_i,
  input  logic      reset_i,
  mem_bus_if.target bus
);

  localparam int unsigned IdxWidth = $clog2(mempool_system_pkg::BootromNumWords);

  mempool_system_pkg::addr_t word_idx;
  mempool_system_pkg::data_t rdata_d, rdata_q;
  logic                      rvalid_q;
  logic                      err_q;

  assign word_idx = (bus.addr - mempool_system_pkg::BootromBaseAddr) >> 2;

  always_comb begin
    rdata_d = '0;
    if (bus.req && !bus.we && word_idx < mempool_system_pkg::BootromNumWords) begin
      rdata_d = mempool_system_pkg::BootromWords[word_idx[IdxWidth-1:0]];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req && bus.we;  // Read-only
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

endmodule : bootrom

//--- hdl/l2_mem.sv
// Banked L2 memory, word interleaved over NumL2Banks banks
// Byte-enable writes, read data returned one cycle after the request

module l2_mem (
  input  logic      clk_i,
  input  logic      reset_i,
  mem_bus_if.target bus
);

  localparam int unsigned BankLsb = 2; // Byte offset within a word
  localparam int unsigned RowLsb  = BankLsb + $bits(mempool_system_pkg::bank_idx_t);

  mempool_system_pkg::bank_idx_t  bank_idx, bank_idx_q;
  mempool_system_pkg::bank_addr_t row;
  mempool_system_pkg::data_t      bank_rdata [mempool_system_pkg::NumL2Banks];
  logic                           rvalid_q;
  logic                           we_q;

  // Lowest word address bits pick the bank, next bits the row
  assign bank_idx = bus.addr[BankLsb +: $bits(mempool_system_pkg::bank_idx_t)];
  assign row      = bus.addr[RowLsb +: $bits(mempool_system_pkg::bank_addr_t)];

  for (genvar b = 0; b < mempool_system_pkg::NumL2Banks; b++) begin : gen_banks
    mempool_system_pkg::data_t mem_q [mempool_system_pkg::L2BankNumWords];
    logic                      bank_req;

    assign bank_req = bus.req && (bank_idx == mempool_system_pkg::bank_idx_t'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (bus.we) begin
          for (int i = 0; i < $bits(mempool_system_pkg::strb_t); i++) begin
            if (bus.be[i]) begin
              mem_q[row][i*8 +: 8] <= bus.wdata[i*8 +: 8];
            end
          end
        end else begin
          bank_rdata[b] <= mem_q[row];
        end
      end
    end
  end

  // Bank index travels with rvalid to select the returning bank
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q   <= 1'b0;
      we_q       <= 1'b0;
      bank_idx_q <= '0;
    end else begin
      rvalid_q <= bus.req;
      if (bus.req) begin
        we_q       <= bus.we;
        bank_idx_q <= bank_idx;
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = (rvalid_q && !we_q) ? bank_rdata[bank_idx_q] : '0; // Writes return zero
  assign bus.err    = 1'b0;   // Decoder only forwards L2 addresses

endmodule : l2_mem

//--- hdl/addr_decoder.sv
// Address decoder for the host port
// Routes each request to one target and steers its response back one cycle later

module addr_decoder (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      req_i,
  input  logic                      we_i,
  input  mempool_system_pkg::addr_t addr_i,
  input  mempool_system_pkg::data_t wdata_i,
  input  mempool_system_pkg::strb_t be_i,
  output logic                      rvalid_o,
  output mempool_system_pkg::data_t rdata_o,
  output logic                      err_o,

  mem_bus_if.initiator              l2,
  mem_bus_if.initiator              rom,
  mem_bus_if.initiator              ctrl
);

  localparam mempool_system_pkg::addr_t L2EndAddr =
    mempool_system_pkg::L2BaseAddr + mempool_system_pkg::L2Size;

  mempool_system_pkg::target_e sel_d, sel_q;
  logic                        req_q; // Request pending for the error responder

  // Region select
  always_comb begin
    sel_d = mempool_system_pkg::TgtNone;
    if (addr_i >= mempool_system_pkg::L2BaseAddr && addr_i < L2EndAddr) begin
      sel_d = mempool_system_pkg::TgtL2;
    end else if (addr_i >= mempool_system_pkg::BootromBaseAddr &&
                 addr_i <= mempool_system_pkg::BootromEndAddr) begin
      sel_d = mempool_system_pkg::TgtBootrom; // End address is inclusive
    end else if (addr_i >= mempool_system_pkg::CtrlBaseAddr &&
                 addr_i < mempool_system_pkg::CtrlEndAddr) begin
      sel_d = mempool_system_pkg::TgtCtrl;
    end
  end

  // Only the selected target sees req
  assign l2.req   = req_i && (sel_d == mempool_system_pkg::TgtL2);
  assign rom.req  = req_i && (sel_d == mempool_system_pkg::TgtBootrom);
  assign ctrl.req = req_i && (sel_d == mempool_system_pkg::TgtCtrl);

  // Request fields are shared
  assign l2.we      = we_i;
  assign l2.addr    = addr_i;
  assign l2.wdata   = wdata_i;
  assign l2.be      = be_i;
  assign rom.we     = we_i;
  assign rom.addr   = addr_i;
  assign rom.wdata  = wdata_i;
  assign rom.be     = be_i;
  assign ctrl.we    = we_i;
  assign ctrl.addr  = addr_i;
  assign ctrl.wdata = wdata_i;
  assign ctrl.be    = be_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q <= mempool_system_pkg::TgtNone;
      req_q <= 1'b0;
    end else begin
      sel_q <= sel_d;
      req_q <= req_i;
    end
  end

  // Response steering
  always_comb begin
    unique case (sel_q)
      mempool_system_pkg::TgtL2: begin
        rvalid_o = l2.rvalid;
        rdata_o  = l2.rdata;
        err_o    = l2.err;
      end
      mempool_system_pkg::TgtBootrom: begin
        rvalid_o = rom.rvalid;
        rdata_o  = rom.rdata;
        err_o    = rom.err;
      end
      mempool_system_pkg::TgtCtrl: begin
        rvalid_o = ctrl.rvalid;
        rdata_o  = ctrl.rdata;
        err_o    = ctrl.err;
      end
      default: begin            // Unmapped, answer with an error
        rvalid_o = req_q;
        rdata_o  = '0;
        err_o    = req_q;
      end
    endcase
  end

endmodule : addr_decoder

//--- hdl/mem_bus_if.sv
// Memory bus between the address decoder and its targets
// Request is taken in the cycle req is high, response follows one cycle later

interface mem_bus_if;

  logic                      req;
  logic                      we;
  mempool_system_pkg::addr_t addr;
  mempool_system_pkg::data_t wdata;
  mempool_system_pkg::strb_t be;

  logic                      rvalid;
  mempool_system_pkg::data_t rdata;
  logic                      err;   // Rejected access, rdata is zero

  modport initiator (
    output req, we, addr, wdata, be,
    input  rvalid, rdata, err
  );

  modport target (
    input  req, we, addr, wdata, be,
    output rvalid, rdata, err
  );

endinterface

//--- hdl/mempool_system_pkg.sv
// MemPool system package
// Widths, address map, control register offsets and boot ROM contents

package mempool_system_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Cores that can be woken up
  localparam int unsigned NumCores = 8;
  typedef logic [NumCores-1:0] core_mask_t;

  // L2 organisation, word interleaved over the banks
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2Size         = NumL2Banks * L2BankNumWords * $bits(data_t) / 8;

  typedef logic [$clog2(NumL2Banks)-1:0]     bank_idx_t;
  typedef logic [$clog2(L2BankNumWords)-1:0] bank_addr_t;

  // Address map
  localparam addr_t L2BaseAddr      = 32'h8000_0000;
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA000_FFFF; // Last byte of the region
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4001_0000; // First byte past the region

  // Response source tracked by the decoder
  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  // Control register offsets from CtrlBaseAddr
  localparam addr_t EocOffset      = 32'h0000_0000;
  localparam addr_t WakeUpOffset   = 32'h0000_0004;
  localparam addr_t NumCoresOffset = 32'h0000_0008;

  // Wake-up value that wakes every core
  localparam data_t WakeAll = 32'hFFFF_FFFF;

  // Boot program
  localparam int unsigned BootromNumWords = 8;

  localparam data_t BootromWords [BootromNumWords] = '{
    32'hF140_2573, // csrr a0, mhartid
    32'h0000_0297, // auipc t0, 0
    32'h0202_8293, // addi t0, t0, 32
    32'h3052_9073, // csrw mtvec, t0
    32'h0080_0593, // li a1, 8
    32'h3040_5073, // csrwi mie, 0
    32'h1050_0073, // wfi
    32'hFFDF_F06F  // j back to wfi
  };

endpackage
